// ==== rtl/datapath_pkg.sv ====
package datapath_pkg;

	// Word and register file geometry
	localparam int WORD_W     = 32;
	localparam int REG_ADDR_W = 4;
	localparam int NUM_REGS   = 16;

	// Sequential fetch advances one word
	localparam logic [WORD_W-1:0] PC_STEP = WORD_W'(4);

	// Low bits of operand B taken as shift or rotate count
	localparam int SHAMT_W = 5;

	typedef enum logic [1:0] {
		PC_HOLD,
		PC_PLUS4,
		PC_ALU,
		PC_RF_A
	} pc_src_e;

	typedef enum logic [1:0] {
		MA_HOLD,
		MA_PC,
		MA_ALU
	} ma_src_e;

	typedef enum logic [1:0] {
		MD_HOLD,
		MD_MEM,
		MD_RF_B
	} md_src_e;

	typedef enum logic {
		ALU_A_RF,
		ALU_A_PC
	} alu_a_src_e;

	typedef enum logic {
		ALU_B_RF,
		ALU_B_CONST
	} alu_b_src_e;

	// Write-back source, RF_NONE leaves the register file alone
	typedef enum logic [2:0] {
		RF_NONE,
		RF_ALU,
		RF_HI,
		RF_LO,
		RF_MD
	} rf_src_e;

	typedef enum logic [3:0] {
		OP_ADD,
		OP_SUB,
		OP_AND,
		OP_OR,
		OP_SHR,
		OP_SHL,
		OP_ROR,
		OP_ROL,
		OP_MUL,
		OP_NEG,
		OP_NOT
	} alu_op_e;

endpackage

// ==== rtl/pc_unit.sv ====
`timescale 1ns/1ps

module pc_unit (
	input  logic                            clk,
	input  logic                            rst_n,
	input  datapath_pkg::pc_src_e           pc_src,
	input  logic [datapath_pkg::WORD_W-1:0] alu_z,
	input  logic [datapath_pkg::WORD_W-1:0] rf_a_data,
	output logic [datapath_pkg::WORD_W-1:0] pc_q
);
	import datapath_pkg::*;

	logic [WORD_W-1:0] pc_plus_step;
	logic [WORD_W-1:0] pc_next;

	// Incrementer, wraps at the top of the address space
	assign pc_plus_step = pc_q + PC_STEP;

	always_comb begin
		case (pc_src)
			PC_PLUS4: pc_next = pc_plus_step;
			PC_ALU:   pc_next = alu_z;
			PC_RF_A:  pc_next = rf_a_data;
			default:  pc_next = pc_q;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc_q <= '0;
		end else begin
			pc_q <= pc_next;
		end
	end

	// Sequential step moves the PC by exactly one word
	a_pc_step: assert property (@(posedge clk) disable iff (!rst_n)
		pc_src == PC_PLUS4 |=> pc_q == $past(pc_q) + PC_STEP)
		else $error("PC did not advance by PC_STEP");

endmodule

// ==== rtl/memory_port.sv ====
`timescale 1ns/1ps

module memory_port (
	input  logic                            clk,
	input  logic                            rst_n,
	input  datapath_pkg::ma_src_e           ma_src,
	input  datapath_pkg::md_src_e           md_src,
	input  logic                            ir_en,
	input  logic [datapath_pkg::WORD_W-1:0] pc_q,
	input  logic [datapath_pkg::WORD_W-1:0] alu_z,
	input  logic [datapath_pkg::WORD_W-1:0] rf_b_data,
	input  logic [datapath_pkg::WORD_W-1:0] data_from_memory,
	output logic [datapath_pkg::WORD_W-1:0] address_to_memory,
	output logic [datapath_pkg::WORD_W-1:0] data_to_memory,
	output logic [datapath_pkg::WORD_W-1:0] md_q,
	output logic [datapath_pkg::WORD_W-1:0] ir_out
);
	import datapath_pkg::*;

	logic [WORD_W-1:0] ma_q;
	logic [WORD_W-1:0] ma_next;
	logic [WORD_W-1:0] md_next;

	// MA source select
	always_comb begin
		case (ma_src)
			MA_PC:   ma_next = pc_q;
			MA_ALU:  ma_next = alu_z;
			default: ma_next = ma_q;
		endcase
	end

	// MD is loaded from the bus on reads, from register B for stores
	always_comb begin
		case (md_src)
			MD_MEM:  md_next = data_from_memory;
			MD_RF_B: md_next = rf_b_data;
			default: md_next = md_q;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ma_q   <= '0;
			md_q   <= '0;
			ir_out <= '0;
		end else begin
			ma_q <= ma_next;
			md_q <= md_next;
			// IR samples the old MD
			if (ir_en) begin
				ir_out <= md_q;
			end
		end
	end

	assign address_to_memory = ma_q;
	assign data_to_memory    = md_q;

	a_mem_data_known: assert property (@(posedge clk) disable iff (!rst_n)
		md_src == MD_MEM |-> !$isunknown(data_from_memory))
		else $error("Unknown bits on data_from_memory during MD load");

endmodule

// ==== rtl/alu_unit.sv ====
`timescale 1ns/1ps

module alu_unit (
	input  logic                            clk,
	input  logic                            rst_n,
	input  datapath_pkg::alu_a_src_e        alu_a_src,
	input  datapath_pkg::alu_b_src_e        alu_b_src,
	input  datapath_pkg::alu_op_e           alu_op,
	input  logic                            hilo_en,
	input  logic [datapath_pkg::WORD_W-1:0] pc_q,
	input  logic [datapath_pkg::WORD_W-1:0] rf_a_data,
	input  logic [datapath_pkg::WORD_W-1:0] rf_b_data,
	input  logic [datapath_pkg::WORD_W-1:0] constant_c,
	output logic [datapath_pkg::WORD_W-1:0] alu_z,
	output logic [datapath_pkg::WORD_W-1:0] hi_q,
	output logic [datapath_pkg::WORD_W-1:0] lo_q
);
	import datapath_pkg::*;

	logic [WORD_W-1:0]          a_op;
	logic [WORD_W-1:0]          b_op;
	logic [SHAMT_W-1:0]         shamt;
	logic [2*WORD_W-1:0]        rot_r;
	logic [2*WORD_W-1:0]        rot_l;
	logic signed [2*WORD_W-1:0] product;

	// Operand A is the PC for branch targets, else register A
	assign a_op = (alu_a_src == ALU_A_PC) ? pc_q : rf_a_data;

	// Constant C arrives already sign extended
	assign b_op = (alu_b_src == ALU_B_CONST) ? constant_c : rf_b_data;

	assign shamt = b_op[SHAMT_W-1:0];

	// Rotates by shifting a doubled copy of A
	assign rot_r = {a_op, a_op} >> shamt;
	assign rot_l = {a_op, a_op} << shamt;

	assign product = $signed(a_op) * $signed(b_op);

	always_comb begin
		case (alu_op)
			OP_ADD: begin
				alu_z = a_op + b_op;
			end
			OP_SUB: begin
				alu_z = a_op - b_op;
			end
			OP_AND: begin
				alu_z = a_op & b_op;
			end
			OP_OR: begin
				alu_z = a_op | b_op;
			end
			OP_SHR: begin
				alu_z = a_op >> shamt;
			end
			OP_SHL: begin
				alu_z = a_op << shamt;
			end
			OP_ROR: begin
				alu_z = rot_r[WORD_W-1:0];
			end
			OP_ROL: begin
				alu_z = rot_l[2*WORD_W-1:WORD_W];
			end
			OP_MUL: begin
				alu_z = product[WORD_W-1:0];
			end
			OP_NEG: begin
				alu_z = '0 - a_op;
			end
			OP_NOT: begin
				alu_z = ~a_op;
			end
			default: begin
				alu_z = '0;
			end
		endcase
	end

	// HI and LO keep the full product for later moves into the register file
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			hi_q <= '0;
			lo_q <= '0;
		end else if (hilo_en) begin
			hi_q <= product[2*WORD_W-1:WORD_W];
			lo_q <= product[WORD_W-1:0];
		end
	end

	a_hilo_mul_only: assert property (@(posedge clk) disable iff (!rst_n)
		hilo_en |-> alu_op == OP_MUL)
		else $error("HI/LO load outside a multiply");

endmodule

// ==== rtl/register_file.sv ====
`timescale 1ns/1ps

module register_file (
	input  logic                                clk,
	input  logic                                rst_n,
	input  datapath_pkg::rf_src_e               rf_src,
	input  logic [datapath_pkg::REG_ADDR_W-1:0] rf_z_addr,
	input  logic [datapath_pkg::REG_ADDR_W-1:0] rf_a_addr,
	input  logic [datapath_pkg::REG_ADDR_W-1:0] rf_b_addr,
	input  logic [datapath_pkg::WORD_W-1:0]     alu_z,
	input  logic [datapath_pkg::WORD_W-1:0]     hi_q,
	input  logic [datapath_pkg::WORD_W-1:0]     lo_q,
	input  logic [datapath_pkg::WORD_W-1:0]     md_q,
	output logic [datapath_pkg::WORD_W-1:0]     rf_a_data,
	output logic [datapath_pkg::WORD_W-1:0]     rf_b_data
);
	import datapath_pkg::*;

	logic [WORD_W-1:0] regs [NUM_REGS];
	logic [WORD_W-1:0] wb_data;
	logic              wr_en;

	// Write-back source select
	always_comb begin
		case (rf_src)
			RF_ALU:  wb_data = alu_z;
			RF_HI:   wb_data = hi_q;
			RF_LO:   wb_data = lo_q;
			RF_MD:   wb_data = md_q;
			default: wb_data = '0;
		endcase
	end

	// r0 is hardwired to zero, so writes to it are dropped
	assign wr_en = (rf_src != RF_NONE) && (rf_z_addr != '0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			regs <= '{default: '0};
		end else if (wr_en) begin
			regs[rf_z_addr] <= wb_data;
		end
	end

	// Reads see the value from before this cycle's write
	assign rf_a_data = (rf_a_addr == '0) ? '0 : regs[rf_a_addr];
	assign rf_b_data = (rf_b_addr == '0) ? '0 : regs[rf_b_addr];

	a_wb_data_known: assert property (@(posedge clk) disable iff (!rst_n)
		wr_en |-> !$isunknown(wb_data))
		else $error("Unknown bits in register write-back data");

endmodule

// ==== rtl/datapath.sv ====
`timescale 1ns/1ps

module datapath (
	input  logic                                clk,
	input  logic                                rst_n,
	input  datapath_pkg::pc_src_e               pc_src,
	input  datapath_pkg::ma_src_e               ma_src,
	input  datapath_pkg::md_src_e               md_src,
	input  logic                                ir_en,
	input  datapath_pkg::alu_a_src_e            alu_a_src,
	input  datapath_pkg::alu_b_src_e            alu_b_src,
	input  datapath_pkg::alu_op_e               alu_op,
	input  logic                                hilo_en,
	input  datapath_pkg::rf_src_e               rf_src,
	input  logic [datapath_pkg::REG_ADDR_W-1:0] rf_a_addr,
	input  logic [datapath_pkg::REG_ADDR_W-1:0] rf_b_addr,
	input  logic [datapath_pkg::REG_ADDR_W-1:0] rf_z_addr,
	input  logic [datapath_pkg::WORD_W-1:0]     constant_c,
	input  logic [datapath_pkg::WORD_W-1:0]     data_from_memory,
	output logic [datapath_pkg::WORD_W-1:0]     address_to_memory,
	output logic [datapath_pkg::WORD_W-1:0]     data_to_memory,
	output logic [datapath_pkg::WORD_W-1:0]     ir_out
);
	import datapath_pkg::*;

	// The three buses: A and B out of the register file, Z out of the ALU
	logic [WORD_W-1:0] rf_a_data;
	logic [WORD_W-1:0] rf_b_data;
	logic [WORD_W-1:0] alu_z;

	logic [WORD_W-1:0] pc_q;
	logic [WORD_W-1:0] hi_q;
	logic [WORD_W-1:0] lo_q;
	logic [WORD_W-1:0] md_q;

	pc_unit pc_unit_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.pc_src    (pc_src),
		.alu_z     (alu_z),
		.rf_a_data (rf_a_data),
		.pc_q      (pc_q)
	);

	memory_port memory_port_i (
		.clk               (clk),
		.rst_n             (rst_n),
		.ma_src            (ma_src),
		.md_src            (md_src),
		.ir_en             (ir_en),
		.pc_q              (pc_q),
		.alu_z             (alu_z),
		.rf_b_data         (rf_b_data),
		.data_from_memory  (data_from_memory),
		.address_to_memory (address_to_memory),
		.data_to_memory    (data_to_memory),
		.md_q              (md_q),
		.ir_out            (ir_out)
	);

	alu_unit alu_unit_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.alu_a_src  (alu_a_src),
		.alu_b_src  (alu_b_src),
		.alu_op     (alu_op),
		.hilo_en    (hilo_en),
		.pc_q       (pc_q),
		.rf_a_data  (rf_a_data),
		.rf_b_data  (rf_b_data),
		.constant_c (constant_c),
		.alu_z      (alu_z),
		.hi_q       (hi_q),
		.lo_q       (lo_q)
	);

	register_file register_file_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.rf_src    (rf_src),
		.rf_z_addr (rf_z_addr),
		.rf_a_addr (rf_a_addr),
		.rf_b_addr (rf_b_addr),
		.alu_z     (alu_z),
		.hi_q      (hi_q),
		.lo_q      (lo_q),
		.md_q      (md_q),
		.rf_a_data (rf_a_data),
		.rf_b_data (rf_b_data)
	);

endmodule

// ==== dv/clk_gen.sv ====
`timescale 1ns/1ps

module clk_gen #(
	parameter int PERIOD_NS    = 4,
	parameter int RESET_CYCLES = 8
) (
	output logic clk,
	output logic rst_n
);
	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2.0) clk = ~clk;
	end

	// Release lands just after an edge, away from DUT sampling
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst_n = 1'b1;
	end
endmodule

// ==== dv/datapath_tb.sv ====
`timescale 1ns/1ps

module datapath_tb;
	import datapath_pkg::*;

	localparam int CLK_PERIOD   = 4;
	localparam int RESET_CYCLES = 8;
	localparam int DRIVE_DELAY  = 1;
	localparam int N_MUL        = 6;
	localparam int FETCH_STEPS  = 6;
	// Reset, checks after reset, load/read, ALU ops in two modes, multiply, fetch, IR
	localparam int PLANNED_CYCLES = RESET_CYCLES + 2 + 2 * 3 + 2 * 10 * 6 + N_MUL * 9
		+ FETCH_STEPS + 5 + 5;

	logic                  clk;
	logic                  rst_n;
	pc_src_e               pc_src;
	ma_src_e               ma_src;
	md_src_e               md_src;
	logic                  ir_en;
	alu_a_src_e            alu_a_src;
	alu_b_src_e            alu_b_src;
	alu_op_e               alu_op;
	logic                  hilo_en;
	rf_src_e               rf_src;
	logic [REG_ADDR_W-1:0] rf_a_addr;
	logic [REG_ADDR_W-1:0] rf_b_addr;
	logic [REG_ADDR_W-1:0] rf_z_addr;
	logic [WORD_W-1:0]     constant_c;
	logic [WORD_W-1:0]     data_from_memory;
	logic [WORD_W-1:0]     address_to_memory;
	logic [WORD_W-1:0]     data_to_memory;
	logic [WORD_W-1:0]     ir_out;

	integer seed = 68;

	clk_gen #(
		.PERIOD_NS    (CLK_PERIOD),
		.RESET_CYCLES (RESET_CYCLES)
	) clk_gen_i (
		.clk   (clk),
		.rst_n (rst_n)
	);

	datapath dut_i (
		.clk               (clk),
		.rst_n             (rst_n),
		.pc_src            (pc_src),
		.ma_src            (ma_src),
		.md_src            (md_src),
		.ir_en             (ir_en),
		.alu_a_src         (alu_a_src),
		.alu_b_src         (alu_b_src),
		.alu_op            (alu_op),
		.hilo_en           (hilo_en),
		.rf_src            (rf_src),
		.rf_a_addr         (rf_a_addr),
		.rf_b_addr         (rf_b_addr),
		.rf_z_addr         (rf_z_addr),
		.constant_c        (constant_c),
		.data_from_memory  (data_from_memory),
		.address_to_memory (address_to_memory),
		.data_to_memory    (data_to_memory),
		.ir_out            (ir_out)
	);

	// Expected ALU result and the two product halves
	function automatic logic [WORD_W-1:0] alu_model(
		input  alu_op_e           op,
		input  logic [WORD_W-1:0] a,
		input  logic [WORD_W-1:0] b,
		output logic [WORD_W-1:0] hi,
		output logic [WORD_W-1:0] lo
	);
		logic [WORD_W-1:0] z;
		logic [WORD_W-1:0] r;
		longint            prod;
		int                sh;
		int                i;
		sh = int'(b[SHAMT_W-1:0]);
		prod = longint'($signed(a)) * longint'($signed(b));
		hi = prod[63:32];
		lo = prod[31:0];
		r = a;
		case (op)
			OP_ADD: z = a + b;
			OP_SUB: z = a - b;
			OP_AND: z = a & b;
			OP_OR:  z = a | b;
			OP_SHR: z = a >> sh;
			OP_SHL: z = a << sh;
			OP_ROR: begin
				// LSB wraps to the top on each step
				for (i = 0; i < sh; i++) begin
					r = {r[0], r[WORD_W-1:1]};
				end
				z = r;
			end
			OP_ROL: begin
				for (i = 0; i < sh; i++) begin
					r = {r[WORD_W-2:0], r[WORD_W-1]};
				end
				z = r;
			end
			OP_MUL: z = prod[31:0];
			OP_NEG: z = ~a + 32'd1;
			OP_NOT: z = ~a;
			default: z = '0;
		endcase
		return z;
	endfunction

	function automatic logic [WORD_W-1:0] rand_word();
		return $random(seed);
	endfunction

	task automatic check(input string name, input logic [WORD_W-1:0] expected,
			input logic [WORD_W-1:0] actual);
		if (actual !== expected) begin
			$display("Fail %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
			$display("Result: FAILED");
			$fatal(1, "Value mismatch in %s", name);
		end
	endtask

	// Every select back to HOLD/NONE between steps
	task automatic idle_controls();
		pc_src    = PC_HOLD;
		ma_src    = MA_HOLD;
		md_src    = MD_HOLD;
		ir_en     = 1'b0;
		alu_a_src = ALU_A_RF;
		alu_b_src = ALU_B_RF;
		alu_op    = OP_ADD;
		hilo_en   = 1'b0;
		rf_src    = RF_NONE;
		rf_a_addr = '0;
		rf_b_addr = '0;
		rf_z_addr = '0;
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#(DRIVE_DELAY);
		idle_controls();
	endtask

	// Memory bus into MD, then MD into the register
	task automatic load_reg(input logic [REG_ADDR_W-1:0] r, input logic [WORD_W-1:0] value);
		data_from_memory = value;
		md_src = MD_MEM;
		next_cycle();
		rf_src = RF_MD;
		rf_z_addr = r;
		next_cycle();
	endtask

	task automatic read_reg(input logic [REG_ADDR_W-1:0] r, output logic [WORD_W-1:0] value);
		md_src = MD_RF_B;
		rf_b_addr = r;
		next_cycle();
		value = data_to_memory;
	endtask

	task automatic alu_test(input alu_op_e op, input logic use_const);
		logic [WORD_W-1:0] a;
		logic [WORD_W-1:0] b_reg;
		logic [WORD_W-1:0] c;
		logic [WORD_W-1:0] z_exp;
		logic [WORD_W-1:0] hi_exp;
		logic [WORD_W-1:0] lo_exp;
		logic [WORD_W-1:0] got;
		string             tag;
		a = rand_word();
		b_reg = rand_word();
		c = rand_word();
		tag = $sformatf("%s %s", op.name(), use_const ? "const" : "reg");
		z_exp = alu_model(op, a, use_const ? c : b_reg, hi_exp, lo_exp);
		load_reg(4'd1, a);
		load_reg(4'd2, b_reg);
		constant_c = c;
		if (use_const) begin
			alu_b_src = ALU_B_CONST;
		end else begin
			alu_b_src = ALU_B_RF;
		end
		rf_a_addr = 4'd1;
		rf_b_addr = 4'd2;
		alu_op = op;
		ma_src = MA_ALU;
		rf_src = RF_ALU;
		rf_z_addr = 4'd3;
		next_cycle();
		check({tag, " to MA"}, z_exp, address_to_memory);
		read_reg(4'd3, got);
		check({tag, " to register"}, z_exp, got);
	endtask

	task automatic mul_test();
		logic [WORD_W-1:0] a;
		logic [WORD_W-1:0] b;
		logic [WORD_W-1:0] z_exp;
		logic [WORD_W-1:0] hi_exp;
		logic [WORD_W-1:0] lo_exp;
		logic [WORD_W-1:0] got;
		a = rand_word();
		b = rand_word();
		z_exp = alu_model(OP_MUL, a, b, hi_exp, lo_exp);
		load_reg(4'd4, a);
		load_reg(4'd5, b);
		rf_a_addr = 4'd4;
		rf_b_addr = 4'd5;
		alu_op = OP_MUL;
		hilo_en = 1'b1;
		ma_src = MA_ALU;
		next_cycle();
		check("MUL low to MA", z_exp, address_to_memory);
		rf_src = RF_HI;
		rf_z_addr = 4'd6;
		next_cycle();
		rf_src = RF_LO;
		rf_z_addr = 4'd7;
		next_cycle();
		read_reg(4'd6, got);
		check("MUL HI", hi_exp, got);
		read_reg(4'd7, got);
		check("MUL LO", lo_exp, got);
	endtask

	task automatic fetch_test();
		logic [WORD_W-1:0] pc_exp;
		logic [WORD_W-1:0] target;
		int                k;
		// PC has held at zero since reset
		pc_exp = '0;
		for (k = 0; k < FETCH_STEPS; k++) begin
			pc_src = PC_PLUS4;
			ma_src = MA_PC;
			next_cycle();
			check($sformatf("fetch step %0d", k), pc_exp, address_to_memory);
			pc_exp = pc_exp + PC_STEP;
		end
		target = rand_word() & ~32'h3;
		load_reg(4'd8, target);
		pc_src = PC_RF_A;
		rf_a_addr = 4'd8;
		next_cycle();
		pc_src = PC_PLUS4;
		ma_src = MA_PC;
		next_cycle();
		check("fetch after jump", target, address_to_memory);
		pc_src = PC_PLUS4;
		ma_src = MA_PC;
		next_cycle();
		check("fetch after jump plus one", target + PC_STEP, address_to_memory);
	endtask

	task automatic ir_test();
		logic [WORD_W-1:0] w1;
		logic [WORD_W-1:0] w2;
		w1 = rand_word();
		w2 = rand_word();
		check("IR before enable", '0, ir_out);
		data_from_memory = w1;
		md_src = MD_MEM;
		next_cycle();
		ir_en = 1'b1;
		next_cycle();
		check("IR first load", w1, ir_out);
		// MD changes underneath while IR is not enabled
		data_from_memory = w2;
		md_src = MD_MEM;
		next_cycle();
		check("MD second word", w2, data_to_memory);
		check("IR hold", w1, ir_out);
		next_cycle();
		check("IR hold idle", w1, ir_out);
		ir_en = 1'b1;
		next_cycle();
		check("IR second load", w2, ir_out);
	endtask

	initial begin
		#(PLANNED_CYCLES * CLK_PERIOD * 2);
		$display("Result: FAILED");
		$fatal(1, "Timeout: the run did not finish within %0d cycles", 2 * PLANNED_CYCLES);
	end

	initial begin
		logic [WORD_W-1:0]     word;
		logic [WORD_W-1:0]     got;
		logic [REG_ADDR_W-1:0] r;
		alu_op_e               op;
		int                    i;
		idle_controls();
		constant_c = '0;
		data_from_memory = '0;
		wait (rst_n === 1'b1);
		next_cycle();

		check("reset address_to_memory", '0, address_to_memory);
		check("reset data_to_memory", '0, data_to_memory);
		check("reset ir_out", '0, ir_out);

		word = rand_word();
		r = word[REG_ADDR_W-1:0];
		if (r == '0) begin
			r = 4'd9;
		end
		word = rand_word();
		load_reg(r, word);
		read_reg(r, got);
		check($sformatf("load and read r%0d", r), word, got);
		load_reg(4'd0, rand_word());
		read_reg(4'd0, got);
		check("load and read r0", '0, got);

		for (i = 0; i <= int'(OP_NOT); i++) begin
			op = alu_op_e'(i);
			if (op != OP_MUL) begin
				alu_test(op, 1'b0);
				alu_test(op, 1'b1);
			end
		end

		for (i = 0; i < N_MUL; i++) begin
			mul_test();
		end

		fetch_test();
		ir_test();

		$display("Result: PASSED");
		$finish;
	end
endmodule

// ==== sources.f ====
rtl/datapath_pkg.sv
rtl/pc_unit.sv
rtl/memory_port.sv
rtl/alu_unit.sv
rtl/register_file.sv
rtl/datapath.sv
dv/clk_gen.sv
dv/datapath_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile with Verilator and run; exit status follows the simulation result
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f sources.f \
	--top-module datapath_tb \
	-o datapath_sim \
	&& ./obj_dir/datapath_sim \
	|| { echo "Simulation or build failed"; exit 1; }
